//--- vlog.f
+incdir+hdl
+incdir+tests
hdl/stbuf_pkg.sv
hdl/store_format.sv
hdl/stbuf_entries.sv
hdl/stbuf_fwd.sv
hdl/lsu_stbuf.sv
tests/tb_lsu_stbuf.sv

//--- Makefile
# Verilator flow for the store buffer testbench

VERILATOR  ?= verilator
TOP        ?= tb_lsu_stbuf
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/stbuf_model.svh
// store buffer reference model
// queue of expected entries in store order with their verdicts,
// a byte-wise store split and the forwarding image of a word
`ifndef STBUF_MODEL_SVH
`define STBUF_MODEL_SVH

localparam int WA_W   = `SB_ADDR_W - `SB_OFS_W;    // word address width
localparam int LANE_W = `SB_DATA_W / `SB_BYTE_W;

sb_entry_t exp_q[$];   // oldest at the front

// place each byte of the store at its own offset, one word or two
function automatic void split_store(input st_req_t req, output sb_wr_t lo, output sb_wr_t hi);
   int nbytes;
   int pos;
   lo = '0;
   hi = '0;
   lo.waddr = req.addr[`SB_ADDR_W-1:`SB_OFS_W];
   hi.waddr = lo.waddr + WA_W'(1);
   case (req.size)
      SZ_BYTE: nbytes = 1;
      SZ_HALF: nbytes = 2;
      default: nbytes = `SB_BYTE_W;
   endcase
   for (int b = 0; b < nbytes; b++) begin
      pos = int'(req.addr[`SB_OFS_W-1:0]) + b;
      if (pos < `SB_BYTE_W) begin
         lo.byteen[pos] = 1'b1;
         lo.data[pos*LANE_W +: LANE_W] = req.data[b*LANE_W +: LANE_W];
      end else begin
         hi.byteen[pos-`SB_BYTE_W] = 1'b1;   // spills into the next word
         hi.data[(pos-`SB_BYTE_W)*LANE_W +: LANE_W] = req.data[b*LANE_W +: LANE_W];
      end
   end
endfunction

function automatic void record_store(input st_req_t req, input logic verdict);
   sb_wr_t    lo;
   sb_wr_t    hi;
   sb_entry_t e;
   split_store(req, lo, hi);
   e.wr        = lo;
   e.valid     = 1'b1;
   e.committed = verdict;
   e.flushed   = ~verdict;
   exp_q.push_back(e);
   if (|hi.byteen) begin
      e.wr = hi;
      exp_q.push_back(e);
   end
endfunction

// next entry the drain port should show, flushed ones dropped
function automatic bit next_committed(output sb_entry_t e);
   e = '0;
   while (exp_q.size() > 0 && exp_q[0].flushed) begin
      void'(exp_q.pop_front());
   end
   if (exp_q.size() == 0) begin
      return 1'b0;
   end
   e = exp_q.pop_front();
   return 1'b1;
endfunction

// per-byte view of one word, later stores overwrite earlier ones
function automatic void forward_image(input logic [WA_W-1:0] waddr,
                                      output logic [`SB_BYTE_W-1:0] be,
                                      output logic [`SB_DATA_W-1:0] data);
   be   = '0;
   data = '0;
   foreach (exp_q[i]) begin
      if (!exp_q[i].flushed && exp_q[i].wr.waddr == waddr) begin
         for (int j = 0; j < `SB_BYTE_W; j++) begin
            if (exp_q[i].wr.byteen[j]) begin
               be[j] = 1'b1;
               data[j*LANE_W +: LANE_W] = exp_q[i].wr.data[j*LANE_W +: LANE_W];
            end
         end
      end
   end
endfunction

`endif

//--- tests/tb_lsu_stbuf.sv
// store buffer testbench
// directed tests for store split, commit and flush, in-order drain,
// the full flag and store-to-load forwarding
`timescale 1ns/1ps
`include "stbuf_params.svh"

module tb_lsu_stbuf;
   import stbuf_pkg::*;

   `include "stbuf_model.svh"

   localparam int CLK_PERIOD     = 4;
   localparam int RESET_CYCLES   = 8;
   localparam int SEED           = 33;
   localparam int DRAIN_LIMIT    = 4 * `SB_DEPTH;
   localparam int TIMEOUT_CYCLES = 2000;   // over ten times the full run

   logic                  clk;
   logic                  rst_n;
   logic                  store_vld;
   st_req_t               store_req;
   logic                  commit_vld;
   logic                  commit;
   logic                  drain_pop;
   logic                  load_vld;
   logic [`SB_ADDR_W-1:0] load_addr;
   logic                  drain_vld;
   drain_t                drain_entry;
   logic                  full;
   logic                  empty;
   logic [`SB_BYTE_W-1:0] fwd_byteen;
   logic [`SB_DATA_W-1:0] fwd_data;

   int errors;
   int checks;
   int tests_run;
   int cycle_cnt;
   logic full_in_window;   // full seen while the last store sat in the window

   lsu_stbuf i_dut (
      .clk(clk), .rst_n(rst_n),
      .store_vld(store_vld), .store_req(store_req),
      .commit_vld(commit_vld), .commit(commit),
      .drain_pop(drain_pop), .drain_vld(drain_vld), .drain_entry(drain_entry),
      .load_vld(load_vld), .load_addr(load_addr),
      .fwd_byteen(fwd_byteen), .fwd_data(fwd_data),
      .full(full), .empty(empty)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD/2) clk = ~clk;

   // ------------------------------------------------------------
   // check and driver helpers
   // ------------------------------------------------------------
   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      checks++;
      assert (cond === 1'b1) else begin
         $display("ERROR %s", what);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int e0);
      tests_run++;
      $display("%s: %s, %0d errors", name, (errors == e0) ? "passed" : "failed", errors - e0);
   endtask

   function automatic st_req_t make_req(input logic [WA_W-1:0] waddr,
                                        input logic [`SB_OFS_W-1:0] ofs, input size_e size);
      st_req_t req;
      req.addr = {waddr, ofs};
      req.size = size;
      req.data = $urandom();
      return req;
   endfunction

   // store, then the verdict two cycles later
   task automatic issue_store(input st_req_t req, input logic verdict);
      @(negedge clk);
      expect_true(!full, "store issued while the buffer was full");
      @(posedge clk);
      store_vld <= 1'b1;
      store_req <= req;
      @(posedge clk);                     // entries written here
      store_vld <= 1'b0;
      @(negedge clk);
      full_in_window = full;              // entries plus the store in the window
      @(posedge clk);
      commit_vld <= 1'b1;
      commit     <= verdict;
      @(posedge clk);                     // verdict applied here
      commit_vld <= 1'b0;
      record_store(req, verdict);
   endtask

   task automatic drain_all();
      int        guard;
      bit        found;
      sb_entry_t exp_e;
      guard = 0;
      @(posedge clk);
      drain_pop <= 1'b1;
      @(negedge clk);
      while (!empty && guard < DRAIN_LIMIT) begin
         if (drain_vld) begin           // head pops on the next edge
            found = next_committed(exp_e);
            if (found) begin
               compare_value("drain_entry.waddr", 64'(drain_entry.waddr), 64'(exp_e.wr.waddr));
               compare_value("drain_entry.byteen", 64'(drain_entry.byteen),
                             64'(exp_e.wr.byteen));
               compare_value("drain_entry.data", 64'(drain_entry.data), 64'(exp_e.wr.data));
            end else begin
               expect_true(1'b0, "drain port offered an entry with no committed store left");
            end
         end
         guard++;
         @(negedge clk);
      end
      expect_true(empty, "buffer did not empty while draining");
      found = next_committed(exp_e);
      expect_true(!found, "a committed store was never drained");
      exp_q.delete();
      @(posedge clk);
      drain_pop <= 1'b0;
   endtask

   task automatic load_word(input logic [`SB_ADDR_W-1:0] addr);
      @(posedge clk);
      load_vld  <= 1'b1;
      load_addr <= addr;
      @(posedge clk);
      load_vld <= 1'b0;
      @(negedge clk);                     // result registered at the edge above
   endtask

   // ------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------
   task automatic reset_values();
      int e0;
      e0 = errors;
      @(negedge clk);
      compare_value("empty", 64'(empty), 64'd1);
      compare_value("full", 64'(full), 64'd0);
      compare_value("drain_vld", 64'(drain_vld), 64'd0);
      compare_value("fwd_byteen", 64'(fwd_byteen), 64'd0);
      finish_test("reset values", e0);
   endtask

   task automatic aligned_stores();
      int e0;
      e0 = errors;
      issue_store(make_req(WA_W'($urandom()), 2'($urandom_range(3)), SZ_BYTE), 1'b1);
      issue_store(make_req(WA_W'($urandom()), {1'($urandom_range(1)), 1'b0}, SZ_HALF), 1'b1);
      issue_store(make_req(WA_W'($urandom()), 2'd0, SZ_WORD), 1'b1);
      drain_all();
      finish_test("aligned stores", e0);
   endtask

   task automatic unaligned_split();
      int e0;
      e0 = errors;
      issue_store(make_req(WA_W'($urandom()), 2'(1 + $urandom_range(2)), SZ_WORD), 1'b1);
      issue_store(make_req(WA_W'($urandom()), 2'd3, SZ_HALF), 1'b1);   // one byte each side
      drain_all();
      finish_test("unaligned split", e0);
   endtask

   task automatic flushed_store();
      int e0;
      e0 = errors;
      issue_store(make_req(WA_W'($urandom()), 2'd0, SZ_WORD), 1'b1);
      issue_store(make_req(WA_W'($urandom()), 2'd0, SZ_WORD), 1'b0);
      issue_store(make_req(WA_W'($urandom()), 2'd0, SZ_WORD), 1'b1);
      drain_all();
      // flushed split store alone at the head, dropped without a pop
      issue_store(make_req(WA_W'($urandom()), 2'd2, SZ_WORD), 1'b0);
      drain_all();
      finish_test("flushed store", e0);
   endtask

   task automatic fill_to_full();
      int e0;
      int n;
      e0 = errors;
      n  = 0;
      for (int i = 0; i < `SB_DEPTH; i++) begin
         @(negedge clk);
         if (full) begin
            break;
         end
         issue_store(make_req(WA_W'($urandom()), 2'd0, SZ_WORD), 1'b1);
         n++;
         // valid entries plus the one store still in the commit window
         compare_value("full", 64'(full_in_window),
                       64'(exp_q.size() + 1 > `SB_DEPTH - 2));
         @(negedge clk);                  // commit window idle here
         compare_value("full", 64'(full), 64'(exp_q.size() > `SB_DEPTH - 2));
      end
      compare_value("stores before full", 64'(n), 64'(`SB_DEPTH - 1));
      drain_all();
      @(negedge clk);
      compare_value("empty", 64'(empty), 64'd1);
      compare_value("full", 64'(full), 64'd0);
      finish_test("fill to full", e0);
   endtask

   task automatic load_forwarding();
      int                    e0;
      logic [WA_W-1:0]       wa;
      logic [`SB_BYTE_W-1:0] be;
      logic [`SB_DATA_W-1:0] dat;
      e0 = errors;
      wa = WA_W'($urandom());
      issue_store(make_req(wa, 2'd0, SZ_HALF), 1'b1);   // lanes 0 and 1
      issue_store(make_req(wa, 2'd1, SZ_HALF), 1'b1);   // lanes 1 and 2, younger
      issue_store(make_req(wa, 2'd3, SZ_BYTE), 1'b0);   // flushed, lane 3 stays off
      forward_image(wa, be, dat);
      load_word({wa, 2'($urandom_range(3))});
      compare_value("fwd_byteen", 64'(fwd_byteen), 64'(be));
      compare_value("fwd_data", 64'(fwd_data), 64'(dat));
      load_word({wa ^ WA_W'('h2a5), 2'd0});             // unrelated word
      compare_value("fwd_byteen", 64'(fwd_byteen), 64'd0);
      compare_value("fwd_data", 64'(fwd_data), 64'd0);
      drain_all();
      finish_test("load forwarding", e0);
   endtask

   // ------------------------------------------------------------
   // run control
   // ------------------------------------------------------------
   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      errors     = 0;
      checks     = 0;
      tests_run  = 0;
      rst_n      = 1'b0;
      store_vld  = 1'b0;
      store_req  = '0;
      commit_vld = 1'b0;
      commit     = 1'b0;
      drain_pop  = 1'b0;
      load_vld   = 1'b0;
      load_addr  = '0;
      void'($urandom(SEED));              // seeds the generator
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      reset_values();
      aligned_stores();
      unaligned_split();
      flushed_store();
      fill_to_full();
      load_forwarding();

      $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- hdl/lsu_stbuf.sv
// store buffer top
// store formatter feeding the entry queue, with load forwarding
// reading the queue contents
`timescale 1ns/1ps
`include "stbuf_params.svh"

module lsu_stbuf (
   input  logic                    clk,
   input  logic                    rst_n,

   // store side
   input  logic                    store_vld,
   input  stbuf_pkg::st_req_t      store_req,
   input  logic                    commit_vld,
   input  logic                    commit,        // 1 commit, 0 flush

   // memory side
   input  logic                    drain_pop,
   output logic                    drain_vld,
   output stbuf_pkg::drain_t       drain_entry,

   // load side
   input  logic                    load_vld,
   input  logic [`SB_ADDR_W-1:0]   load_addr,
   output logic [`SB_BYTE_W-1:0]   fwd_byteen,
   output logic [`SB_DATA_W-1:0]   fwd_data,

   output logic                    full,
   output logic                    empty
);
   import stbuf_pkg::*;

   sb_wr_t                    wr_lo;
   sb_wr_t                    wr_hi;
   logic                      dual;
   sb_entry_t [`SB_DEPTH-1:0] entries;
   logic [`SB_PTR_W-1:0]      wr_ptr;

   store_format i_store_format (
      .req   (store_req),
      .wr_lo (wr_lo),
      .wr_hi (wr_hi),
      .dual  (dual)
   );

   stbuf_entries i_stbuf_entries (
      .clk         (clk),
      .rst_n       (rst_n),
      .store_vld   (store_vld),
      .wr_lo       (wr_lo),
      .wr_hi       (wr_hi),
      .dual        (dual),
      .commit_vld  (commit_vld),
      .commit      (commit),
      .drain_pop   (drain_pop),
      .entries     (entries),
      .wr_ptr      (wr_ptr),
      .drain_vld   (drain_vld),
      .drain_entry (drain_entry),
      .full        (full),
      .empty       (empty)
   );

   stbuf_fwd i_stbuf_fwd (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_vld   (load_vld),
      .load_addr  (load_addr),
      .entries    (entries),
      .wr_ptr     (wr_ptr),
      .fwd_byteen (fwd_byteen),
      .fwd_data   (fwd_data)
   );

endmodule

//--- hdl/stbuf_fwd.sv
// store-to-load forwarding
// matches a load word address against the buffered entries and merges
// their bytes, youngest entry per lane wins, result registered on load_vld
`timescale 1ns/1ps
`include "stbuf_params.svh"

module stbuf_fwd (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 load_vld,
   input  logic [`SB_ADDR_W-1:0]                load_addr,
   input  stbuf_pkg::sb_entry_t [`SB_DEPTH-1:0] entries,
   input  logic [`SB_PTR_W-1:0]                 wr_ptr,
   output logic [`SB_BYTE_W-1:0]                fwd_byteen,
   output logic [`SB_DATA_W-1:0]                fwd_data
);
   import stbuf_pkg::*;

   localparam int BYTE_BITS = `SB_DATA_W / `SB_BYTE_W;

   logic [`SB_ADDR_W-`SB_OFS_W-1:0] load_waddr;
   logic [`SB_DEPTH-1:0]            hit;
   logic [`SB_BYTE_W-1:0]           byteen_c;
   logic [`SB_DATA_W-1:0]           data_c;

   assign load_waddr = load_addr[`SB_ADDR_W-1:`SB_OFS_W];

   // ------------------------------------------------------------
   // address match
   // ------------------------------------------------------------
   // committed and pending entries both forward, flushed ones never
   always_comb begin
      for (int i = 0; i < `SB_DEPTH; i++) begin
         hit[i] = entries[i].valid & ~entries[i].flushed &
                  (entries[i].wr.waddr == load_waddr);
      end
   end

   // ------------------------------------------------------------
   // byte merge
   // ------------------------------------------------------------
   // wr_ptr points at the oldest slot, so younger hits overwrite lanes
   always_comb begin : merge
      logic [`SB_PTR_W-1:0] idx;
      sb_entry_t            ent;

      byteen_c = '0;
      data_c   = '0;
      for (int k = 0; k < `SB_DEPTH; k++) begin
         idx = wr_ptr + `SB_PTR_W'(k);
         ent = entries[idx];
         for (int j = 0; j < `SB_BYTE_W; j++) begin
            if (hit[idx] & ent.wr.byteen[j]) begin
               byteen_c[j] = 1'b1;
               data_c[j*BYTE_BITS +: BYTE_BITS] = ent.wr.data[j*BYTE_BITS +: BYTE_BITS];
            end
         end
      end
   end

   // ------------------------------------------------------------
   // result registers, held until the next load
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fwd_byteen <= '0;
      end else if (load_vld) begin
         fwd_byteen <= byteen_c;
      end
   end

   always_ff @(posedge clk) begin
      if (load_vld) begin
         fwd_data <= data_c;   // unmatched lanes already zero
      end
   end

endmodule

//--- hdl/stbuf_entries.sv
// store buffer entry array
// circular queue of word entries with write and read pointers, a two-stage
// commit window that marks entries committed or flushed, the in-order drain
// port and the full/empty flags
`timescale 1ns/1ps
`include "stbuf_params.svh"

module stbuf_entries (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 store_vld,
   input  stbuf_pkg::sb_wr_t                    wr_lo,
   input  stbuf_pkg::sb_wr_t                    wr_hi,
   input  logic                                 dual,
   input  logic                                 commit_vld,
   input  logic                                 commit,
   input  logic                                 drain_pop,
   output stbuf_pkg::sb_entry_t [`SB_DEPTH-1:0] entries,
   output logic [`SB_PTR_W-1:0]                 wr_ptr,
   output logic                                 drain_vld,
   output stbuf_pkg::drain_t                    drain_entry,
   output logic                                 full,
   output logic                                 empty
);
   import stbuf_pkg::*;

   localparam int CNT_W = `SB_PTR_W + 2;   // valid plus pending reaches 2x depth

   // one stage of the commit window
   typedef struct packed {
      logic                 vld;
      logic [`SB_PTR_W-1:0] ptr;    // first entry of the store
      logic                 dual;   // second entry at ptr+1
   } cmt_stage_t;

   sb_wr_t                 payload [`SB_DEPTH];
   logic [`SB_DEPTH-1:0]   vld_q;
   logic [`SB_DEPTH-1:0]   cmt_q;
   logic [`SB_DEPTH-1:0]   fls_q;

   logic [`SB_PTR_W-1:0]   wr_ptr_q;
   logic [`SB_PTR_W-1:0]   rd_ptr_q;
   logic [`SB_PTR_W-1:0]   wr_ptr_p1;
   logic [`SB_PTR_W-1:0]   cmt_ptr_p1;

   cmt_stage_t             stg1_q;
   cmt_stage_t             stg2_q;

   logic [`SB_DEPTH-1:0]   wr_lo_en;
   logic [`SB_DEPTH-1:0]   wr_hi_en;
   logic [`SB_DEPTH-1:0]   cmt_en;
   logic [`SB_DEPTH-1:0]   pop_en;
   logic                   head_flushed;
   logic                   pop;

   logic [CNT_W-1:0]       num_vld;
   logic [CNT_W-1:0]       num_pend;

   assign wr_ptr_p1  = wr_ptr_q + 1'b1;
   assign cmt_ptr_p1 = stg2_q.ptr + 1'b1;

   // ------------------------------------------------------------
   // per-entry enables
   // ------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < `SB_DEPTH; i++) begin
         wr_lo_en[i] = store_vld & (wr_ptr_q == `SB_PTR_W'(i));
         wr_hi_en[i] = store_vld & dual & (wr_ptr_p1 == `SB_PTR_W'(i));
         cmt_en[i]   = commit_vld & stg2_q.vld &
                       ((stg2_q.ptr == `SB_PTR_W'(i)) |
                        (stg2_q.dual & (cmt_ptr_p1 == `SB_PTR_W'(i))));
         pop_en[i]   = pop & (rd_ptr_q == `SB_PTR_W'(i));
      end
   end

   // payload, written only into free entries
   always_ff @(posedge clk) begin
      for (int i = 0; i < `SB_DEPTH; i++) begin
         if (wr_lo_en[i]) begin
            payload[i] <= wr_lo;
         end else if (wr_hi_en[i]) begin
            payload[i] <= wr_hi;
         end
      end
   end

   // entry state bits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q <= '0;
         cmt_q <= '0;
         fls_q <= '0;
      end else begin
         for (int i = 0; i < `SB_DEPTH; i++) begin
            if (wr_lo_en[i] | wr_hi_en[i]) begin
               vld_q[i] <= 1'b1;
               cmt_q[i] <= 1'b0;
               fls_q[i] <= 1'b0;
            end else if (pop_en[i]) begin
               vld_q[i] <= 1'b0;
               cmt_q[i] <= 1'b0;
               fls_q[i] <= 1'b0;
            end else if (cmt_en[i]) begin
               cmt_q[i] <= commit;   // verdict for the store
               fls_q[i] <= ~commit;
            end
         end
      end
   end

   // ------------------------------------------------------------
   // pointers and commit window
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         stg1_q   <= '0;
         stg2_q   <= '0;
      end else begin
         if (store_vld) begin
            wr_ptr_q <= dual ? wr_ptr_p1 + 1'b1 : wr_ptr_p1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         stg1_q.vld  <= store_vld;
         stg1_q.ptr  <= wr_ptr_q;
         stg1_q.dual <= store_vld & dual;
         stg2_q      <= stg1_q;          // lines up with commit_vld
      end
   end

   // ------------------------------------------------------------
   // drain port
   // ------------------------------------------------------------
   assign head_flushed = vld_q[rd_ptr_q] & fls_q[rd_ptr_q];   // dropped silently
   assign drain_vld    = vld_q[rd_ptr_q] & cmt_q[rd_ptr_q];
   assign pop          = (drain_pop & drain_vld) | head_flushed;

   assign drain_entry.waddr  = payload[rd_ptr_q].waddr;
   assign drain_entry.byteen = payload[rd_ptr_q].byteen;
   assign drain_entry.data   = payload[rd_ptr_q].data;

   // occupancy, window stores counted by entries
   always_comb begin
      num_vld = '0;
      for (int i = 0; i < `SB_DEPTH; i++) begin
         num_vld = num_vld + CNT_W'(vld_q[i]);
      end
   end

   assign num_pend = CNT_W'(stg1_q.vld) + CNT_W'(stg1_q.dual) +
                     CNT_W'(stg2_q.vld) + CNT_W'(stg2_q.dual);

   // headroom of two so a split store always fits
   assign full  = (num_vld + num_pend) > CNT_W'(`SB_DEPTH - 2);
   assign empty = ~|vld_q;

   // array view for forwarding
   always_comb begin
      for (int i = 0; i < `SB_DEPTH; i++) begin
         entries[i].wr        = payload[i];
         entries[i].valid     = vld_q[i];
         entries[i].committed = cmt_q[i];
         entries[i].flushed   = fls_q[i];
      end
   end

   assign wr_ptr = wr_ptr_q;

endmodule

//--- hdl/store_format.sv
// store formatter
// shifts a store request into byte lanes and splits it into one or two
// word-aligned entry writes, low word first
`timescale 1ns/1ps
`include "stbuf_params.svh"

module store_format (
   input  stbuf_pkg::st_req_t req,
   output stbuf_pkg::sb_wr_t  wr_lo,
   output stbuf_pkg::sb_wr_t  wr_hi,
   output logic               dual
);
   import stbuf_pkg::*;

   localparam int BYTE_BITS = `SB_DATA_W / `SB_BYTE_W;

   logic [`SB_OFS_W-1:0]              ofs;
   logic [`SB_ADDR_W-`SB_OFS_W-1:0]   waddr;
   logic [2*`SB_BYTE_W-1:0]           size_be;    // enables before the shift
   logic [2*`SB_BYTE_W-1:0]           be_win;     // two-word window
   logic [2*`SB_DATA_W-1:0]           data_sh;
   logic [2*`SB_DATA_W-1:0]           data_win;

   assign ofs   = req.addr[`SB_OFS_W-1:0];
   assign waddr = req.addr[`SB_ADDR_W-1:`SB_OFS_W];

   // ------------------------------------------------------------
   // size decode
   // ------------------------------------------------------------
   always_comb begin
      size_be = '0;
      case (req.size)
         SZ_BYTE: size_be[0]   = 1'b1;
         SZ_HALF: size_be[1:0] = '1;
         default: size_be[`SB_BYTE_W-1:0] = '1;
      endcase
   end

   // ------------------------------------------------------------
   // shift into the window by the byte offset
   // ------------------------------------------------------------
   assign be_win  = size_be << ofs;
   assign data_sh = {{`SB_DATA_W{1'b0}}, req.data} << (ofs * BYTE_BITS);

   // lanes without an enable carry zero
   always_comb begin
      data_win = data_sh;
      for (int j = 0; j < 2*`SB_BYTE_W; j++) begin
         if (!be_win[j]) begin
            data_win[j*BYTE_BITS +: BYTE_BITS] = '0;
         end
      end
   end

   // split into the two words
   assign wr_lo.waddr  = waddr;
   assign wr_lo.byteen = be_win[`SB_BYTE_W-1:0];
   assign wr_lo.data   = data_win[`SB_DATA_W-1:0];

   assign wr_hi.waddr  = waddr + 1'b1;                  // next word, wraps at top
   assign wr_hi.byteen = be_win[2*`SB_BYTE_W-1:`SB_BYTE_W];
   assign wr_hi.data   = data_win[2*`SB_DATA_W-1:`SB_DATA_W];

   assign dual = |be_win[2*`SB_BYTE_W-1:`SB_BYTE_W];    // crosses a word boundary

endmodule

//--- hdl/stbuf_pkg.sv
// store buffer types
// store request, entry write, stored entry and drain word
`include "stbuf_params.svh"

package stbuf_pkg;

   // access size of a store
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   typedef struct packed {
      logic [`SB_ADDR_W-1:0] addr;   // byte address
      size_e                 size;
      logic [`SB_DATA_W-1:0] data;   // unshifted, lsb aligned
   } st_req_t;

   // one word-aligned write into the array
   typedef struct packed {
      logic [`SB_ADDR_W-`SB_OFS_W-1:0] waddr;
      logic [`SB_BYTE_W-1:0]           byteen;
      logic [`SB_DATA_W-1:0]           data;    // already in byte lanes
   } sb_wr_t;

   typedef struct packed {
      sb_wr_t wr;
      logic   valid;
      logic   committed;
      logic   flushed;
   } sb_entry_t;

   // head entry offered to memory
   typedef struct packed {
      logic [`SB_ADDR_W-`SB_OFS_W-1:0] waddr;
      logic [`SB_BYTE_W-1:0]           byteen;
      logic [`SB_DATA_W-1:0]           data;
   } drain_t;

endpackage

//--- hdl/stbuf_params.svh
// store buffer sizing
// depth, word, byte lane and address widths shared by the buffer RTL
`ifndef STBUF_PARAMS_SVH
`define STBUF_PARAMS_SVH

// entry count, power of two and at least 2
`define SB_DEPTH   4
`define SB_PTR_W   2     // log2 of SB_DEPTH

`define SB_DATA_W  32    // word width
`define SB_BYTE_W  4     // byte lanes per word

// byte address and the byte offset inside a word
`define SB_ADDR_W  16
`define SB_OFS_W   2     // log2 of SB_BYTE_W

`endif
